// ==== dv/valu_chk.sv ====
// Protocol assertions bound into the lane slice top level
// Checks are off while reset is low
`timescale 1ns/1ps
`include "valu_consts.svh"

module valu_chk (
  input logic                        clk_i,
  input logic                        rst_ni,
  input valu_lane_pkg::valu_result_t result_i,
  input logic                        req_i,
  input logic                        gnt_i,
  input logic [1:0]                  operand_valid_i,
  input logic [1:0]                  operand_ready_i,
  input logic [`VALU_NR_VINSN-1:0]   done_i
);
  import valu_isa_pkg::*;
  import valu_lane_pkg::*;

  int unsigned fires = 0;

  // Ungranted request keeps its record
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && !gnt_i |=> req_i && $stable(result_i))
    else begin
      $error("result request dropped or changed before its grant");
      fires++;
    end

  // At most one done bit, and only on the id of the record being granted
  done_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(done_i) && (done_i == '0 || (req_i && gnt_i && done_i[result_i.id])))
    else begin
      $error("done pulse with several bits or without a grant of that id");
      fires++;
    end

  // Only valid operands get consumed
  ready_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (operand_ready_i & ~operand_valid_i) == 2'b00)
    else begin
      $error("operand ready raised for an invalid operand");
      fires++;
    end

endmodule

bind valu_top valu_chk u_chk (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .result_i        (result_o),
  .req_i           (result_req_o),
  .gnt_i           (result_gnt_i),
  .operand_valid_i (operand_valid_i),
  .operand_ready_i (operand_ready_o),
  .done_i          (vinsn_done_o)
);

// ==== dv/valu_tb.sv ====
// Directed tests of the lane slice with a word-level reference model
// Grant is only raised while a request is pending
`timescale 1ns/1ps
`include "valu_consts.svh"

module valu_tb;
  import valu_isa_pkg::*;
  import valu_lane_pkg::*;

  localparam int TIMEOUT = 2000;

  logic clk, rst_n;
  valu_insn_t insn;
  logic insn_valid, insn_ready;
  elen_t [1:0] operand;
  logic [1:0] operand_valid, operand_ready;
  valu_result_t result;
  logic result_req, result_gnt;
  logic [`VALU_NR_VINSN-1:0] vinsn_done;

  // Operand words waiting to be consumed, expected and seen results
  elen_t vs1_q[$], vs2_q[$];
  valu_result_t exp_res_q[$], obs_res_q[$];
  vid_t exp_done_q[$], obs_done_q[$];
  logic gnt_en;
  int seed = 10932;
  int errors = 0;
  int n_tests = 0;
  int n_failed = 0;

  valu_tb_clk u_clk (.clk_o(clk), .rst_no(rst_n));

  valu_top DUT (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .insn_i          (insn),
    .insn_valid_i    (insn_valid),
    .insn_ready_o    (insn_ready),
    .operand_i       (operand),
    .operand_valid_i (operand_valid),
    .operand_ready_o (operand_ready),
    .result_o        (result),
    .result_req_o    (result_req),
    .result_gnt_i    (result_gnt),
    .vinsn_done_o    (vinsn_done)
  );

  function automatic elen_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // Scalar copied into each element
  function automatic elen_t spread_scalar(input elen_t s, input valu_vew_e vew);
    int unsigned ew;
    logic [63:0] mask;
    elen_t word;
    ew = 32'd8 << vew;
    mask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
    word = '0;
    for (int unsigned e = 0; e < 64 / ew; e++) word |= (s & mask) << (e * ew);
    return word;
  endfunction

  // Reference result of one word
  // a is vs1 or the spread scalar and b is vs2
  function automatic elen_t model_word(input valu_op_e op, input valu_vew_e vew,
                                       input elen_t a, input elen_t b);
    int unsigned ew, sh;
    logic [63:0] mask, ea, eb, er;
    logic signed [63:0] sa, sb;
    elen_t word;
    ew = 32'd8 << vew;
    mask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
    word = '0;
    for (int unsigned e = 0; e < 64 / ew; e++) begin
      ea = (a >> (e * ew)) & mask;
      eb = (b >> (e * ew)) & mask;
      sa = $signed(ea << (64 - ew)) >>> (64 - ew);
      sb = $signed(eb << (64 - ew)) >>> (64 - ew);
      // Low log2(ew) bits of the first operand
      sh = 32'(ea[5:0]) & (ew - 32'd1);
      case (op)
        VAND:    er = ea & eb;
        VOR:     er = ea | eb;
        VXOR:    er = ea ^ eb;
        VADD:    er = ea + eb;
        VSUB:    er = eb - ea;
        VRSUB:   er = ea - eb;
        VSLL:    er = eb << sh;
        VSRL:    er = eb >> sh;
        VSRA:    er = sb >>> sh;
        VMIN:    er = (sa < sb) ? ea : eb;
        VMAX:    er = (sa < sb) ? eb : ea;
        VMINU:   er = (ea < eb) ? ea : eb;
        default: er = (ea < eb) ? eb : ea;
      endcase
      word |= (er & mask) << (e * ew);
    end
    return word;
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("** Error: %s got %h expected %h", sig, got, exp);
    errors++;
  endtask

  task automatic check_result(input valu_result_t exp, input valu_result_t got);
    if (got.id !== exp.id) report_mismatch("result_o.id", 64'(got.id), 64'(exp.id));
    if (got.addr !== exp.addr) report_mismatch("result_o.addr", 64'(got.addr), 64'(exp.addr));
    if (got.wdata !== exp.wdata) report_mismatch("result_o.wdata", got.wdata, exp.wdata);
    if (got.be !== exp.be) report_mismatch("result_o.be", 64'(got.be), 64'(exp.be));
  endtask

  task automatic check_done(input vid_t exp, input vid_t got);
    if (got !== exp) report_mismatch("vinsn_done_o id", 64'(got), 64'(exp));
  endtask

  task automatic check_ready(input logic exp, input logic got);
    if (got !== exp) report_mismatch("insn_ready_o", 64'(got), 64'(exp));
  endtask

  // Queue operands and expected records, then hand the instruction over
  task automatic send_insn(input valu_op_e op, input valu_vew_e vew, input vl_t vl,
                           input logic [`VALU_VREG_W-1:0] vd, input vid_t id,
                           input logic use_scalar, input elen_t scalar,
                           input logic fixed, input elen_t fa, input elen_t fb);
    valu_insn_t ins;
    elen_t a, b, a_eff;
    valu_result_t r;
    logic [`VALU_WIDX_W-1:0] widx;
    int epw, left, n, t;
    logic accepted;
    ins = '{op: op, vew: vew, vl: vl, vd: vd, id: id, scalar_op: scalar,
            use_scalar: use_scalar, use_vs1: !use_scalar, use_vs2: 1'b1};
    epw = 8 >> vew;
    left = int'(vl);
    widx = '0;
    while (left > 0) begin
      a = fixed ? fa : rand_word();
      b = fixed ? fb : rand_word();
      if (!use_scalar) vs1_q.push_back(a);
      vs2_q.push_back(b);
      a_eff = use_scalar ? spread_scalar(scalar, vew) : a;
      n = (left < epw) ? left : epw;
      r.id = id;
      r.addr = {vd, widx};
      r.wdata = model_word(op, vew, a_eff, b);
      // Bytes of the elements still left
      r.be = strb_t'((16'd1 << (n << vew)) - 16'd1);
      exp_res_q.push_back(r);
      left -= n;
      widx++;
    end
    exp_done_q.push_back(id);
    @(posedge clk);
    #1;
    insn = ins;
    insn_valid = 1'b1;
    accepted = 1'b0;
    for (t = 0; !accepted; t++) begin
      if (t >= TIMEOUT) abort_on_timeout("insn_ready_o");
      @(negedge clk);
      if (insn_ready) accepted = 1'b1;
    end
    @(posedge clk);
    #1;
    insn_valid = 1'b0;
  endtask

  // Wait for all expected traffic, compare in order, print the test line
  task automatic finish_test(input string name, input int errs_before);
    int t, errs;
    for (t = 0; obs_res_q.size() < exp_res_q.size() ||
                obs_done_q.size() < exp_done_q.size(); t++) begin
      if (t >= TIMEOUT) abort_on_timeout({"results of test ", name});
      @(negedge clk);
    end
    while (exp_res_q.size() > 0) check_result(exp_res_q.pop_front(), obs_res_q.pop_front());
    while (exp_done_q.size() > 0) check_done(exp_done_q.pop_front(), obs_done_q.pop_front());
    if (obs_res_q.size() > 0 || obs_done_q.size() > 0) begin
      $display("unexpected extra results or done pulses in test %s", name);
      errors++;
      obs_res_q.delete();
      obs_done_q.delete();
    end
    errs = errors - errs_before;
    n_tests++;
    if (errs != 0) n_failed++;
    $display("test %s: %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
  endtask

  task automatic run_arith();
    valu_op_e ops[6];
    int k, e0;
    ops = '{VADD, VSUB, VRSUB, VAND, VOR, VXOR};
    e0 = errors;
    k = 0;
    for (int o = 0; o < 6; o++) begin
      for (int w = 0; w < 4; w++) begin
        send_insn(ops[o], valu_vew_e'(w), vl_t'((8 >> w) * 3), 5'(o * 4 + w + 1),
                  vid_t'(k % 8), 1'b0, '0, 1'b0, '0, '0);
        k++;
      end
    end
    finish_test("arith", e0);
  endtask

  // Random scalars carry junk above the shift amount bits
  task automatic run_shift();
    valu_op_e ops[3];
    int k, e0;
    ops = '{VSLL, VSRL, VSRA};
    e0 = errors;
    k = 0;
    for (int o = 0; o < 3; o++) begin
      for (int w = 0; w < 4; w++) begin
        send_insn(ops[o], valu_vew_e'(w), vl_t'((8 >> w) * 2), 5'(16 + w),
                  vid_t'(k % 8), 1'b1, rand_word(), 1'b0, '0, '0);
        k++;
      end
    end
    finish_test("shift", e0);
  endtask

  // vs1 elements all positive, vs2 elements all with the top bit set
  task automatic run_minmax();
    valu_op_e ops[4];
    int k, e0;
    ops = '{VMIN, VMINU, VMAX, VMAXU};
    e0 = errors;
    k = 0;
    for (int o = 0; o < 4; o++) begin
      for (int w = 0; w < 4; w++) begin
        send_insn(ops[o], valu_vew_e'(w), vl_t'((8 >> w) * 2), 5'(3 + w), vid_t'(k % 8),
                  1'b0, '0, 1'b1, 64'h1234_5678_1357_2468, 64'h9abc_def0_8899_aabb);
        k++;
      end
    end
    finish_test("minmax", e0);
  endtask

  task automatic run_partial();
    int e0;
    e0 = errors;
    send_insn(VADD, EW8, 10'd11, 5'd7, 3'd1, 1'b0, '0, 1'b0, '0, '0);
    send_insn(VSUB, EW16, 10'd6, 5'd8, 3'd2, 1'b0, '0, 1'b0, '0, '0);
    send_insn(VXOR, EW32, 10'd3, 5'd9, 3'd3, 1'b0, '0, 1'b0, '0, '0);
    send_insn(VOR, EW8, 10'd5, 5'd10, 3'd4, 1'b0, '0, 1'b0, '0, '0);
    finish_test("partial", e0);
  endtask

  // Four instructions fill the queue while nothing is granted
  // Two words fill the result queue and the other ten vs2 words must wait
  task automatic run_backpressure();
    int e0;
    e0 = errors;
    gnt_en = 1'b0;
    for (int i = 0; i < 4; i++) begin
      send_insn(VADD, EW64, 10'd3, 5'(20 + i), vid_t'(4 + i), 1'b0, '0, 1'b0, '0, '0);
    end
    @(negedge clk);
    check_ready(1'b0, insn_ready);
    if (result_req !== 1'b1) report_mismatch("result_req_o", 64'(result_req), 64'd1);
    if (operand_ready !== 2'b00) begin
      report_mismatch("operand_ready_o", 64'(operand_ready), 64'd0);
    end
    if (vs2_q.size() != 10) begin
      $display("issue did not stall after two words, %0d vs2 words still queued",
               vs2_q.size());
      errors++;
    end
    gnt_en = 1'b1;
    finish_test("backpressure", e0);
  endtask

  // Operands and grant change 1 ns after each rising edge
  // Each operand is held back now and then so that issue has to wait
  initial begin
    int cyc;
    cyc = 0;
    operand = '0;
    operand_valid = '0;
    result_gnt = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      cyc++;
      operand_valid[0] = (vs1_q.size() > 0) && (cyc % 7 != 2);
      operand_valid[1] = (vs2_q.size() > 0) && (cyc % 5 != 3);
      operand = '0;
      if (operand_valid[0]) operand[0] = vs1_q[0];
      if (operand_valid[1]) operand[1] = vs2_q[0];
      result_gnt = gnt_en && result_req;
    end
  end

  // Monitor at the falling edge where everything is settled
  initial begin
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (operand_ready[0] && vs1_q.size() > 0) vs1_q.delete(0);
        if (operand_ready[1] && vs2_q.size() > 0) vs2_q.delete(0);
        if (result_req && result_gnt) obs_res_q.push_back(result);
        if (vinsn_done != '0 && !(result_req && result_gnt)) begin
          $display("done pulse seen in a cycle without a result grant");
          errors++;
        end
        for (int i = 0; i < `VALU_NR_VINSN; i++) begin
          if (vinsn_done[i]) obs_done_q.push_back(vid_t'(i));
        end
      end
    end
  end

  initial begin
    int t;
    insn = '0;
    insn_valid = 1'b0;
    gnt_en = 1'b1;
    for (t = 0; !rst_n; t++) begin
      if (t >= TIMEOUT) abort_on_timeout("reset release");
      @(posedge clk);
    end
    run_arith();
    run_shift();
    run_minmax();
    run_partial();
    run_backpressure();
    errors += int'(DUT.u_chk.fires);
    $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== dv/valu_tb_clk.sv ====
// Free-running 10 ns clock, reset held low for the first 8 rising edges
`timescale 1ns/1ps

module valu_tb_clk (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release 1 ns after the eighth edge, off the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the lane slice testbench with Verilator, run it, look for the pass line
verilator --binary --timing --assert --top-module valu_tb -f valu_lane.f -o valu_sim \
  && ./obj_dir/valu_sim +verilator+error+limit+1000 | tee /dev/stderr \
     | grep -x "PASS: all tests" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== valu_lane.f ====
+incdir+verilog
verilog/valu_isa_pkg.sv
verilog/valu_lane_pkg.sv
verilog/valu_insn_queue.sv
verilog/valu_simd_alu.sv
verilog/valu_result_queue.sv
verilog/valu_ctrl.sv
verilog/valu_top.sv
dv/valu_tb_clk.sv
dv/valu_chk.sv
dv/valu_tb.sv

// ==== verilog/valu_consts.svh ====
// Widths and depths of the vector ALU lane slice
// Queue depths must stay powers of two since the pointers wrap naturally
`ifndef VALU_CONSTS_SVH
`define VALU_CONSTS_SVH

// Datapath word and its byte enables
`define VALU_ELEN 64
`define VALU_STRB 8

// Queue depths
`define VALU_INSN_DEPTH 4
`define VALU_RES_DEPTH 2

// Instruction ids and vector length
`define VALU_NR_VINSN 8
`define VALU_VL_W 10

// Register-file address is vd joined with the word index
`define VALU_VREG_W 5
`define VALU_WIDX_W 8

`endif

// ==== verilog/valu_ctrl.sv ====
// Issue and commit control of the lane slice
// Word index is 8 bits, so at most 256 words per instruction
`timescale 1ns/1ps
`include "valu_consts.svh"

module valu_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        insn_valid_i,
  input  logic                        queue_full_i,
  input  valu_isa_pkg::valu_insn_t    issue_insn_i,
  input  valu_isa_pkg::valu_insn_t    commit_insn_i,
  input  logic                        issue_valid_i,
  input  logic                        commit_valid_i,
  input  logic [1:0]                  operand_valid_i,
  input  logic                        res_full_i,
  input  logic                        gnt_i,
  input  valu_lane_pkg::elen_t        alu_result_i,
  output logic                        push_o,
  output logic                        issue_pop_o,
  output logic                        commit_pop_o,
  output logic                        res_wr_o,
  output valu_lane_pkg::valu_result_t res_data_o,
  output logic [1:0]                  operand_ready_o,
  output logic                        insn_ready_o,
  output logic [`VALU_NR_VINSN-1:0]   vinsn_done_o
);
  import valu_isa_pkg::*;
  import valu_lane_pkg::*;

  // Elements already handled for the issue and commit heads
  vl_t                     issue_done_q, commit_done_q;
  logic [`VALU_WIDX_W-1:0] widx_q;

  vl_t        issue_rem, commit_rem;
  logic [3:0] issue_per_word, commit_per_word;
  logic [3:0] elem_cnt, nbytes;
  logic       ops_ok, issue_fire, last_issue, last_commit;
  strb_t      be;

  // Instruction handshake
  assign insn_ready_o = !queue_full_i;
  assign push_o       = insn_valid_i && !queue_full_i;

  // Elements per word, 8 at EW8 down to 1 at EW64
  assign issue_per_word  = 4'd8 >> issue_insn_i.vew;
  assign commit_per_word = 4'd8 >> commit_insn_i.vew;
  assign issue_rem       = issue_insn_i.vl - issue_done_q;
  assign commit_rem      = commit_insn_i.vl - commit_done_q;

  assign last_issue = (issue_rem <= vl_t'(issue_per_word));
  assign elem_cnt   = last_issue ? issue_rem[3:0] : issue_per_word;
  assign nbytes     = elem_cnt << issue_insn_i.vew;

  // Only the bytes of remaining elements are written
  always_comb begin
    for (int b = 0; b < `VALU_STRB; b++) begin
      be[b] = (b < nbytes);
    end
  end

  // Every used operand must be there
  assign ops_ok = (operand_valid_i[0] || !issue_insn_i.use_vs1) &&
                  (operand_valid_i[1] || !issue_insn_i.use_vs2);
  assign issue_fire = issue_valid_i && !res_full_i && ops_ok;

  assign operand_ready_o = issue_fire ? {issue_insn_i.use_vs2, issue_insn_i.use_vs1} : 2'b00;
  assign issue_pop_o     = issue_fire && last_issue;
  assign res_wr_o        = issue_fire;
  assign res_data_o      = '{id:    issue_insn_i.id,
                             addr:  {issue_insn_i.vd, widx_q},
                             wdata: alu_result_i,
                             be:    be};

  // Last word of the commit head granted
  assign last_commit  = (commit_rem <= vl_t'(commit_per_word));
  assign commit_pop_o = gnt_i && commit_valid_i && last_commit;

  always_comb begin
    vinsn_done_o = '0;
    if (commit_pop_o) vinsn_done_o[commit_insn_i.id] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_done_q  <= '0;
      commit_done_q <= '0;
      widx_q        <= '0;
    end else begin
      if (issue_fire) begin
        // Next head starts from word zero
        issue_done_q <= last_issue ? '0 : issue_done_q + vl_t'(elem_cnt);
        widx_q       <= last_issue ? '0 : widx_q + 1'b1;
      end
      if (gnt_i && commit_valid_i) begin
        commit_done_q <= last_commit ? '0 : commit_done_q + vl_t'(commit_per_word);
      end
    end
  end

endmodule

// ==== verilog/valu_insn_queue.sv ====
// Instruction ring buffer with separate issue and commit read pointers
// Caller must not push while full_o is high
`timescale 1ns/1ps
`include "valu_consts.svh"

module valu_insn_queue (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     push_i,
  input  valu_isa_pkg::valu_insn_t insn_i,
  input  logic                     issue_pop_i,
  input  logic                     commit_pop_i,
  output valu_isa_pkg::valu_insn_t issue_insn_o,
  output valu_isa_pkg::valu_insn_t commit_insn_o,
  output logic                     issue_valid_o,
  output logic                     commit_valid_o,
  output logic                     full_o
);
  import valu_isa_pkg::*;

  localparam int unsigned PtrW = $clog2(`VALU_INSN_DEPTH);

  valu_insn_t            mem_q [`VALU_INSN_DEPTH];
  logic [PtrW-1:0]       accept_ptr_q, issue_ptr_q, commit_ptr_q;
  // Instructions still waiting to issue and to commit
  logic [PtrW:0]         issue_cnt_q, commit_cnt_q;

  assign issue_insn_o   = mem_q[issue_ptr_q];
  assign commit_insn_o  = mem_q[commit_ptr_q];
  assign issue_valid_o  = (issue_cnt_q != '0);
  assign commit_valid_o = (commit_cnt_q != '0);
  // A slot frees only once its instruction commits
  assign full_o         = (commit_cnt_q == `VALU_INSN_DEPTH);

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[accept_ptr_q] <= insn_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_ptr_q <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
    end else begin
      if (push_i) accept_ptr_q <= accept_ptr_q + 1'b1;
      if (issue_pop_i) issue_ptr_q <= issue_ptr_q + 1'b1;
      if (commit_pop_i) commit_ptr_q <= commit_ptr_q + 1'b1;
      // Counts move by one at most in each direction
      if (push_i && !issue_pop_i) issue_cnt_q <= issue_cnt_q + 1'b1;
      else if (!push_i && issue_pop_i) issue_cnt_q <= issue_cnt_q - 1'b1;
      if (push_i && !commit_pop_i) commit_cnt_q <= commit_cnt_q + 1'b1;
      else if (!push_i && commit_pop_i) commit_cnt_q <= commit_cnt_q - 1'b1;
    end
  end

endmodule

// ==== verilog/valu_isa_pkg.sv ====
// Instruction-level types of the lane slice
// The op encoding is private to this unit and not the RVV encoding
`include "valu_consts.svh"

package valu_isa_pkg;

  // Kept integer operations
  typedef enum logic [3:0] {
    VAND, VOR, VXOR,
    VADD, VSUB, VRSUB,
    VSLL, VSRL, VSRA,
    VMIN, VMINU, VMAX, VMAXU
  } valu_op_e;

  // Element width
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } valu_vew_e;

  typedef logic [$clog2(`VALU_NR_VINSN)-1:0] vid_t;
  typedef logic [`VALU_VL_W-1:0]             vl_t;

  // One accepted instruction
  typedef struct packed {
    valu_op_e                op;
    valu_vew_e               vew;
    vl_t                     vl;
    logic [`VALU_VREG_W-1:0] vd;
    vid_t                    id;
    logic [`VALU_ELEN-1:0]   scalar_op;
    logic                    use_scalar;
    logic                    use_vs1;
    logic                    use_vs2;
  } valu_insn_t;

endpackage

// ==== verilog/valu_lane_pkg.sv ====
// Datapath-level types of the lane slice
`include "valu_consts.svh"

package valu_lane_pkg;

  typedef logic [`VALU_ELEN-1:0] elen_t;
  typedef logic [`VALU_STRB-1:0] strb_t;

  // vd in the upper bits, word index below
  typedef logic [`VALU_VREG_W+`VALU_WIDX_W-1:0] vaddr_t;

  // One register-file write
  typedef struct packed {
    valu_isa_pkg::vid_t id;
    vaddr_t             addr;
    elen_t              wdata;
    strb_t              be;
  } valu_result_t;

endpackage

// ==== verilog/valu_result_queue.sv ====
// Two-entry ring of result records, oldest shown as the write request
// Writer must not write while full_o is high
`timescale 1ns/1ps
`include "valu_consts.svh"

module valu_result_queue (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        wr_i,
  input  valu_lane_pkg::valu_result_t wr_data_i,
  output logic                        full_o,
  input  logic                        gnt_i,
  output logic                        req_o,
  output valu_lane_pkg::valu_result_t rd_data_o
);
  import valu_lane_pkg::*;

  localparam int unsigned PtrW = $clog2(`VALU_RES_DEPTH);

  valu_result_t                 mem_q [`VALU_RES_DEPTH];
  logic [`VALU_RES_DEPTH-1:0]   valid_q;
  logic [PtrW-1:0]              wr_ptr_q, rd_ptr_q;
  logic [PtrW:0]                cnt_q;
  logic                         pop;

  // Head held until granted
  assign req_o     = valid_q[rd_ptr_q];
  assign rd_data_o = mem_q[rd_ptr_q];
  assign pop       = gnt_i && req_o;
  assign full_o    = (cnt_q == `VALU_RES_DEPTH);

  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (wr_i) begin
        valid_q[wr_ptr_q] <= 1'b1;
        wr_ptr_q          <= wr_ptr_q + 1'b1;
      end
      // Write and pop never hit the same entry
      if (pop) begin
        valid_q[rd_ptr_q] <= 1'b0;
        rd_ptr_q          <= rd_ptr_q + 1'b1;
      end
      if (wr_i && !pop) cnt_q <= cnt_q + 1'b1;
      else if (!wr_i && pop) cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

// ==== verilog/valu_simd_alu.sv ====
// Combinational SIMD integer unit on one 64-bit word
// Shift amounts use only the low log2(element width) bits of vs1
`timescale 1ns/1ps
`include "valu_consts.svh"

module valu_simd_alu (
  input  valu_isa_pkg::valu_insn_t       insn_i,
  input  valu_lane_pkg::elen_t     [1:0] operand_i,
  output valu_lane_pkg::elen_t           result_o
);
  import valu_isa_pkg::*;
  import valu_lane_pkg::*;

  // One word viewed at each element width
  typedef union packed {
    logic [0:0][`VALU_ELEN-1:0]   w64;
    logic [1:0][`VALU_ELEN/2-1:0] w32;
    logic [3:0][`VALU_ELEN/4-1:0] w16;
    logic [7:0][`VALU_ELEN/8-1:0] w8;
  } simd_word_t;

  elen_t      scalar_rep;
  simd_word_t opa, opb, res;
  logic       sgn;

  // One element, operands already extended to 65 bits
  // Caller keeps only the low element-width bits
  function automatic logic [64:0] elem_calc(input valu_op_e          op,
                                            input logic signed [64:0] a,
                                            input logic signed [64:0] b,
                                            input logic        [5:0]  sh);
    logic        less;
    logic [64:0] r;
    less = (a < b);
    unique case (op)
      VAND:         r = a & b;
      VOR:          r = a | b;
      VXOR:         r = a ^ b;
      VADD:         r = a + b;
      // vs2 minus vs1
      VSUB:         r = b - a;
      VRSUB:        r = a - b;
      VSLL:         r = b << sh;
      VSRL:         r = b >> sh;
      // b carries the element sign here
      VSRA:         r = b >>> sh;
      VMIN, VMINU:  r = less ? a : b;
      VMAX, VMAXU:  r = less ? b : a;
      default:      r = '0;
    endcase
    return r;
  endfunction

  // Scalar copied into every element
  always_comb begin
    unique case (insn_i.vew)
      EW8:     scalar_rep = {8{insn_i.scalar_op[7:0]}};
      EW16:    scalar_rep = {4{insn_i.scalar_op[15:0]}};
      EW32:    scalar_rep = {2{insn_i.scalar_op[31:0]}};
      default: scalar_rep = insn_i.scalar_op;
    endcase
  end

  assign opa = insn_i.use_scalar ? scalar_rep : operand_i[0];
  assign opb = operand_i[1];

  // Sign extension for arithmetic shift and signed compare
  assign sgn = insn_i.op inside {VSRA, VMIN, VMAX};

  always_comb begin
    logic [64:0] r;
    res = '0;
    unique case (insn_i.vew)
      EW8: begin
        for (int i = 0; i < 8; i++) begin
          r = elem_calc(insn_i.op, {{57{sgn & opa.w8[i][7]}}, opa.w8[i]},
                        {{57{sgn & opb.w8[i][7]}}, opb.w8[i]}, {3'b0, opa.w8[i][2:0]});
          res.w8[i] = r[7:0];
        end
      end
      EW16: begin
        for (int i = 0; i < 4; i++) begin
          r = elem_calc(insn_i.op, {{49{sgn & opa.w16[i][15]}}, opa.w16[i]},
                        {{49{sgn & opb.w16[i][15]}}, opb.w16[i]}, {2'b0, opa.w16[i][3:0]});
          res.w16[i] = r[15:0];
        end
      end
      EW32: begin
        for (int i = 0; i < 2; i++) begin
          r = elem_calc(insn_i.op, {{33{sgn & opa.w32[i][31]}}, opa.w32[i]},
                        {{33{sgn & opb.w32[i][31]}}, opb.w32[i]}, {1'b0, opa.w32[i][4:0]});
          res.w32[i] = r[31:0];
        end
      end
      default: begin
        r = elem_calc(insn_i.op, {sgn & opa.w64[0][63], opa.w64[0]},
                      {sgn & opb.w64[0][63], opb.w64[0]}, opa.w64[0][5:0]);
        res.w64[0] = r[63:0];
      end
    endcase
  end

  assign result_o = res;

endmodule

// ==== verilog/valu_top.sv ====
// Lane slice of the vector integer ALU
// Every offered instruction is taken as meant for this unit
`timescale 1ns/1ps
`include "valu_consts.svh"

module valu_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  valu_isa_pkg::valu_insn_t          insn_i,
  input  logic                              insn_valid_i,
  output logic                              insn_ready_o,
  input  valu_lane_pkg::elen_t        [1:0] operand_i,
  input  logic                        [1:0] operand_valid_i,
  output logic                        [1:0] operand_ready_o,
  output valu_lane_pkg::valu_result_t       result_o,
  output logic                              result_req_o,
  input  logic                              result_gnt_i,
  output logic     [`VALU_NR_VINSN-1:0]     vinsn_done_o
);
  import valu_isa_pkg::*;
  import valu_lane_pkg::*;

  valu_insn_t   issue_insn, commit_insn;
  logic         issue_valid, commit_valid, queue_full;
  logic         push, issue_pop, commit_pop;
  logic         res_wr, res_full;
  valu_result_t res_data;
  elen_t        alu_result;

  valu_insn_queue u_insn_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (push),
    .insn_i         (insn_i),
    .issue_pop_i    (issue_pop),
    .commit_pop_i   (commit_pop),
    .issue_insn_o   (issue_insn),
    .commit_insn_o  (commit_insn),
    .issue_valid_o  (issue_valid),
    .commit_valid_o (commit_valid),
    .full_o         (queue_full)
  );

  // Works on the issue head
  valu_simd_alu u_simd_alu (
    .insn_i    (issue_insn),
    .operand_i (operand_i),
    .result_o  (alu_result)
  );

  valu_result_queue u_result_queue (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr_i      (res_wr),
    .wr_data_i (res_data),
    .full_o    (res_full),
    .gnt_i     (result_gnt_i),
    .req_o     (result_req_o),
    .rd_data_o (result_o)
  );

  valu_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_valid_i    (insn_valid_i),
    .queue_full_i    (queue_full),
    .issue_insn_i    (issue_insn),
    .commit_insn_i   (commit_insn),
    .issue_valid_i   (issue_valid),
    .commit_valid_i  (commit_valid),
    .operand_valid_i (operand_valid_i),
    .res_full_i      (res_full),
    .gnt_i           (result_gnt_i),
    .alu_result_i    (alu_result),
    .push_o          (push),
    .issue_pop_o     (issue_pop),
    .commit_pop_o    (commit_pop),
    .res_wr_o        (res_wr),
    .res_data_o      (res_data),
    .operand_ready_o (operand_ready_o),
    .insn_ready_o    (insn_ready_o),
    .vinsn_done_o    (vinsn_done_o)
  );

endmodule
